/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // register file geometry.
  ////////////////////////////////////////////////////////////////////////////

  localparam int reg_addr_width_gp = 5;
  localparam int reg_els_gp = 32; // x0..x31, f0..f31.

  typedef logic [reg_addr_width_gp-1:0] reg_addr_t;

endpackage

/* hdl/bubble_prof_pkg.sv */
package bubble_prof_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // long-latency operation kinds, one per scoreboard entry.
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    e_long_none,
    e_long_remote_dram,
    e_long_remote_group,
    e_long_remote_global,
    e_long_idiv,
    e_long_fdiv
  } long_op_e;

  // id stage record, filled by control-flow events.
  typedef enum logic [1:0] {
    e_id_none,
    e_id_branch_miss,
    e_id_jalr_miss,
    e_id_icache_miss
  } id_bubble_e;

  ////////////////////////////////////////////////////////////////////////////
  // exe bubble causes. lower value wins.
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    e_exe_none = 5'd0,
    e_exe_branch_miss,
    e_exe_jalr_miss,
    e_exe_icache_miss,
    e_exe_depend_dram,
    e_exe_depend_group,
    e_exe_depend_global,
    e_exe_depend_idiv,
    e_exe_depend_fdiv,
    e_exe_depend_local_load,
    e_exe_depend_imul,
    e_exe_bypass,
    e_exe_fence,
    e_exe_remote_req,
    e_exe_remote_credit,
    e_exe_fdiv_busy,
    e_exe_idiv_busy,
    e_exe_barrier,
    e_exe_blocking_load
  } exe_bubble_e;

  localparam int num_causes_gp = 19; // includes none.
  localparam int cause_sel_width_gp = 5;

  typedef logic [cause_sel_width_gp-1:0] cause_sel_t;

endpackage

/* hdl/long_op_scoreboard.sv */
`timescale 1ns/1ps

module long_op_scoreboard (
  input clk_i
  ,input reset_i

  ,input set_i
  ,input set_float_i
  ,input rv_isa_pkg::reg_addr_t set_id_i
  ,input bubble_prof_pkg::long_op_e set_kind_i

  ,input int_clear_i
  ,input rv_isa_pkg::reg_addr_t int_clear_id_i
  ,input float_clear_i
  ,input rv_isa_pkg::reg_addr_t float_clear_id_i

  ,input rv_isa_pkg::reg_addr_t rs1_i
  ,input rv_isa_pkg::reg_addr_t rs2_i
  ,input rv_isa_pkg::reg_addr_t rd_i
  ,input read_rs1_i
  ,input read_rs2_i
  ,input write_rd_i
  ,input is_float_i

  ,output logic hit_dram_o
  ,output logic hit_group_o
  ,output logic hit_global_o
  ,output logic hit_idiv_o
  ,output logic hit_fdiv_o
);

  bubble_prof_pkg::long_op_e int_sb_r [rv_isa_pkg::reg_els_gp];
  bubble_prof_pkg::long_op_e float_sb_r [rv_isa_pkg::reg_els_gp];

  bubble_prof_pkg::long_op_e rs1_kind, rs2_kind, rd_kind;
  logic [7:0] pend_mask;
  logic set_to_float;
  logic int_holds_fdiv, float_holds_idiv;

  // fdiv results always go to the float file.
  assign set_to_float = set_float_i | (set_kind_i == bubble_prof_pkg::e_long_fdiv);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < rv_isa_pkg::reg_els_gp; i++) begin
        int_sb_r[i] <= bubble_prof_pkg::e_long_none;
        float_sb_r[i] <= bubble_prof_pkg::e_long_none;
      end
    end else begin
      if (set_i & ~set_to_float) int_sb_r[set_id_i] <= set_kind_i;
      if (set_i & set_to_float) float_sb_r[set_id_i] <= set_kind_i;
      // clears come last so they win.
      if (int_clear_i) int_sb_r[int_clear_id_i] <= bubble_prof_pkg::e_long_none;
      if (float_clear_i) float_sb_r[float_clear_id_i] <= bubble_prof_pkg::e_long_none;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // operand lookup.
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rs1_kind = is_float_i ? float_sb_r[rs1_i] : int_sb_r[rs1_i];
    rs2_kind = is_float_i ? float_sb_r[rs2_i] : int_sb_r[rs2_i];
    rd_kind = is_float_i ? float_sb_r[rd_i] : int_sb_r[rd_i];
    pend_mask = '0;
    if (read_rs1_i) pend_mask = pend_mask | (8'd1 << rs1_kind);
    if (read_rs2_i) pend_mask = pend_mask | (8'd1 << rs2_kind);
    if (write_rd_i) pend_mask = pend_mask | (8'd1 << rd_kind);
  end

  assign hit_dram_o = pend_mask[bubble_prof_pkg::e_long_remote_dram];
  assign hit_group_o = pend_mask[bubble_prof_pkg::e_long_remote_group];
  assign hit_global_o = pend_mask[bubble_prof_pkg::e_long_remote_global];
  assign hit_idiv_o = pend_mask[bubble_prof_pkg::e_long_idiv];
  assign hit_fdiv_o = pend_mask[bubble_prof_pkg::e_long_fdiv];

  always_comb begin
    int_holds_fdiv = 1'b0;
    float_holds_idiv = 1'b0;
    for (int i = 0; i < rv_isa_pkg::reg_els_gp; i++) begin
      int_holds_fdiv |= (int_sb_r[i] == bubble_prof_pkg::e_long_fdiv);
      float_holds_idiv |= (float_sb_r[i] == bubble_prof_pkg::e_long_idiv);
    end
  end

  // file contents stay consistent across all set/clear history.
  assert property (@(posedge clk_i) disable iff (reset_i) !int_holds_fdiv)
    else $error("fdiv pending in integer scoreboard.");
  assert property (@(posedge clk_i) disable iff (reset_i) !float_holds_idiv)
    else $error("idiv pending in float scoreboard.");

endmodule

/* hdl/bubble_classifier.sv */
`timescale 1ns/1ps

module bubble_classifier #(
  parameter int pc_width_p = 32
) (
  input clk_i
  ,input reset_i

  ,input [pc_width_p-1:0] if_pc_i
  ,input [pc_width_p-1:0] id_pc_i
  ,input [pc_width_p-1:0] exe_pc_i

  ,input branch_mispredict_i
  ,input jalr_mispredict_i
  ,input icache_miss_i
  ,input icache_miss_in_pipe_i

  ,input stall_all_i
  ,input stall_depend_long_op_i
  ,input stall_depend_local_load_i
  ,input stall_depend_imul_i
  ,input stall_bypass_i
  ,input stall_fence_i
  ,input stall_remote_req_i
  ,input stall_remote_credit_i
  ,input stall_fdiv_busy_i
  ,input stall_idiv_busy_i
  ,input stall_barrier_i
  ,input stall_blocking_load_i

  ,input hit_dram_i
  ,input hit_group_i
  ,input hit_global_i
  ,input hit_idiv_i
  ,input hit_fdiv_i

  ,output bubble_prof_pkg::exe_bubble_e exe_bubble_type_o
  ,output logic [pc_width_p-1:0] exe_bubble_pc_o
);

  logic [pc_width_p-1:0] icache_miss_pc_r;

  bubble_prof_pkg::id_bubble_e id_type_r, id_type_n;
  logic [pc_width_p-1:0] id_pc_r, id_pc_n;

  bubble_prof_pkg::exe_bubble_e exe_type_r, exe_type_n, stall_pick;
  logic [pc_width_p-1:0] exe_pc_r, exe_pc_n;

  logic [bubble_prof_pkg::num_causes_gp-1:0] stall_v;

  // pc of the fetch that missed.
  always_ff @(posedge clk_i) begin
    if (icache_miss_i) icache_miss_pc_r <= if_pc_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // id stage record
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    id_type_n = bubble_prof_pkg::e_id_none;
    id_pc_n = '0;
    if (branch_mispredict_i) begin
      id_type_n = bubble_prof_pkg::e_id_branch_miss;
      id_pc_n = exe_pc_i;
    end else if (jalr_mispredict_i) begin
      id_type_n = bubble_prof_pkg::e_id_jalr_miss;
      id_pc_n = exe_pc_i;
    end else if (icache_miss_in_pipe_i) begin
      id_type_n = bubble_prof_pkg::e_id_icache_miss;
      id_pc_n = icache_miss_pc_r;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // exe stage priority chain
  ////////////////////////////////////////////////////////////////////////////

  // one bit per stall cause, indexed by its exe_bubble_e value.
  always_comb begin
    stall_v = '0;
    stall_v[bubble_prof_pkg::e_exe_depend_dram] = stall_depend_long_op_i & hit_dram_i;
    stall_v[bubble_prof_pkg::e_exe_depend_group] = stall_depend_long_op_i & hit_group_i;
    stall_v[bubble_prof_pkg::e_exe_depend_global] = stall_depend_long_op_i & hit_global_i;
    stall_v[bubble_prof_pkg::e_exe_depend_idiv] = stall_depend_long_op_i & hit_idiv_i;
    stall_v[bubble_prof_pkg::e_exe_depend_fdiv] = stall_depend_long_op_i & hit_fdiv_i;
    stall_v[bubble_prof_pkg::e_exe_depend_local_load] = stall_depend_local_load_i;
    stall_v[bubble_prof_pkg::e_exe_depend_imul] = stall_depend_imul_i;
    stall_v[bubble_prof_pkg::e_exe_bypass] = stall_bypass_i;
    stall_v[bubble_prof_pkg::e_exe_fence] = stall_fence_i;
    stall_v[bubble_prof_pkg::e_exe_remote_req] = stall_remote_req_i;
    stall_v[bubble_prof_pkg::e_exe_remote_credit] = stall_remote_credit_i;
    stall_v[bubble_prof_pkg::e_exe_fdiv_busy] = stall_fdiv_busy_i;
    stall_v[bubble_prof_pkg::e_exe_idiv_busy] = stall_idiv_busy_i;
    stall_v[bubble_prof_pkg::e_exe_barrier] = stall_barrier_i;
    stall_v[bubble_prof_pkg::e_exe_blocking_load] = stall_blocking_load_i;
  end

  // walk down so the lowest set value ends up picked.
  always_comb begin
    stall_pick = bubble_prof_pkg::e_exe_none;
    for (int i = bubble_prof_pkg::num_causes_gp - 1; i > 0; i--) begin
      if (stall_v[i]) begin
        stall_pick = bubble_prof_pkg::exe_bubble_e'(bubble_prof_pkg::cause_sel_t'(i));
      end
    end
  end

  always_comb begin
    exe_type_n = bubble_prof_pkg::e_exe_none;
    exe_pc_n = '0;
    if (branch_mispredict_i) begin
      exe_type_n = bubble_prof_pkg::e_exe_branch_miss;
      exe_pc_n = exe_pc_i;
    end else if (jalr_mispredict_i) begin
      exe_type_n = bubble_prof_pkg::e_exe_jalr_miss;
      exe_pc_n = exe_pc_i;
    end else if (id_type_r != bubble_prof_pkg::e_id_none) begin
      case (id_type_r)
        bubble_prof_pkg::e_id_branch_miss: exe_type_n = bubble_prof_pkg::e_exe_branch_miss;
        bubble_prof_pkg::e_id_jalr_miss: exe_type_n = bubble_prof_pkg::e_exe_jalr_miss;
        default: exe_type_n = bubble_prof_pkg::e_exe_icache_miss;
      endcase
      exe_pc_n = id_pc_r;
    end else if (stall_pick != bubble_prof_pkg::e_exe_none) begin
      exe_type_n = stall_pick;
      exe_pc_n = id_pc_i; // blame the stalled instruction.
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_type_r <= bubble_prof_pkg::e_id_none;
      id_pc_r <= '0;
      exe_type_r <= bubble_prof_pkg::e_exe_none;
      exe_pc_r <= '0;
    end else if (~stall_all_i) begin
      id_type_r <= id_type_n;
      id_pc_r <= id_pc_n;
      exe_type_r <= exe_type_n;
      exe_pc_r <= exe_pc_n;
    end
  end

  assign exe_bubble_type_o = exe_type_r;
  assign exe_bubble_pc_o = exe_pc_r;

  assert property (@(posedge clk_i) disable iff (reset_i)
    (exe_type_r == bubble_prof_pkg::e_exe_none) |-> (exe_pc_r == '0))
    else $error("nonzero bubble pc with no bubble.");

endmodule

/* hdl/bubble_counter_bank.sv */
`timescale 1ns/1ps

module bubble_counter_bank #(
  parameter int cnt_width_p = 32
) (
  input clk_i
  ,input reset_i

  ,input bubble_prof_pkg::exe_bubble_e type_i
  ,input bubble_prof_pkg::cause_sel_t sel_i

  ,output logic [cnt_width_p-1:0] cnt_o
);

  // no counter for none, so the index starts at 1.
  logic [cnt_width_p-1:0] cnt_r [1:bubble_prof_pkg::num_causes_gp-1];

  ////////////////////////////////////////////////////////////////////////////
  // saturating counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < bubble_prof_pkg::num_causes_gp; i++) begin
        cnt_r[i] <= '0;
      end
    end else begin
      for (int i = 1; i < bubble_prof_pkg::num_causes_gp; i++) begin
        if ((bubble_prof_pkg::cause_sel_t'(type_i) == bubble_prof_pkg::cause_sel_t'(i))
            && !(&cnt_r[i])) begin
          cnt_r[i] <= cnt_r[i] + cnt_width_p'(1);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cnt_o = '0; // none and out of range read zero.
    for (int i = 1; i < bubble_prof_pkg::num_causes_gp; i++) begin
      if (sel_i == bubble_prof_pkg::cause_sel_t'(i)) begin
        cnt_o = cnt_r[i];
      end
    end
  end

endmodule

/* hdl/bubble_profiler_top.sv */
`timescale 1ns/1ps

module bubble_profiler_top #(
  parameter int pc_width_p = 32
  ,parameter int cnt_width_p = 32
) (
  input clk_i
  ,input reset_i

  ,input [pc_width_p-1:0] if_pc_i
  ,input [pc_width_p-1:0] id_pc_i
  ,input [pc_width_p-1:0] exe_pc_i

  ,input branch_mispredict_i
  ,input jalr_mispredict_i
  ,input icache_miss_i
  ,input icache_miss_in_pipe_i

  ,input stall_all_i
  ,input stall_depend_long_op_i
  ,input stall_depend_local_load_i
  ,input stall_depend_imul_i
  ,input stall_bypass_i
  ,input stall_fence_i
  ,input stall_remote_req_i
  ,input stall_remote_credit_i
  ,input stall_fdiv_busy_i
  ,input stall_idiv_busy_i
  ,input stall_barrier_i
  ,input stall_blocking_load_i

  ,input rv_isa_pkg::reg_addr_t id_rs1_i
  ,input rv_isa_pkg::reg_addr_t id_rs2_i
  ,input rv_isa_pkg::reg_addr_t id_rd_i
  ,input id_read_rs1_i
  ,input id_read_rs2_i
  ,input id_write_rd_i
  ,input id_is_float_i

  ,input sb_set_i
  ,input sb_set_float_i
  ,input rv_isa_pkg::reg_addr_t sb_set_id_i
  ,input bubble_prof_pkg::long_op_e sb_set_kind_i
  ,input int_sb_clear_i
  ,input rv_isa_pkg::reg_addr_t int_sb_clear_id_i
  ,input float_sb_clear_i
  ,input rv_isa_pkg::reg_addr_t float_sb_clear_id_i

  ,input bubble_prof_pkg::cause_sel_t cnt_sel_i

  ,output bubble_prof_pkg::exe_bubble_e exe_bubble_type_o
  ,output logic [pc_width_p-1:0] exe_bubble_pc_o
  ,output logic [cnt_width_p-1:0] cnt_o
);

  logic hit_dram, hit_group, hit_global, hit_idiv, hit_fdiv;
  bubble_prof_pkg::exe_bubble_e exe_bubble_type;

  long_op_scoreboard sb (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.set_i(sb_set_i)
    ,.set_float_i(sb_set_float_i)
    ,.set_id_i(sb_set_id_i)
    ,.set_kind_i(sb_set_kind_i)
    ,.int_clear_i(int_sb_clear_i)
    ,.int_clear_id_i(int_sb_clear_id_i)
    ,.float_clear_i(float_sb_clear_i)
    ,.float_clear_id_i(float_sb_clear_id_i)
    ,.rs1_i(id_rs1_i)
    ,.rs2_i(id_rs2_i)
    ,.rd_i(id_rd_i)
    ,.read_rs1_i(id_read_rs1_i)
    ,.read_rs2_i(id_read_rs2_i)
    ,.write_rd_i(id_write_rd_i)
    ,.is_float_i(id_is_float_i)
    ,.hit_dram_o(hit_dram)
    ,.hit_group_o(hit_group)
    ,.hit_global_o(hit_global)
    ,.hit_idiv_o(hit_idiv)
    ,.hit_fdiv_o(hit_fdiv)
  );

  bubble_classifier #(.pc_width_p(pc_width_p)) classifier (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.if_pc_i(if_pc_i)
    ,.id_pc_i(id_pc_i)
    ,.exe_pc_i(exe_pc_i)
    ,.branch_mispredict_i(branch_mispredict_i)
    ,.jalr_mispredict_i(jalr_mispredict_i)
    ,.icache_miss_i(icache_miss_i)
    ,.icache_miss_in_pipe_i(icache_miss_in_pipe_i)
    ,.stall_all_i(stall_all_i)
    ,.stall_depend_long_op_i(stall_depend_long_op_i)
    ,.stall_depend_local_load_i(stall_depend_local_load_i)
    ,.stall_depend_imul_i(stall_depend_imul_i)
    ,.stall_bypass_i(stall_bypass_i)
    ,.stall_fence_i(stall_fence_i)
    ,.stall_remote_req_i(stall_remote_req_i)
    ,.stall_remote_credit_i(stall_remote_credit_i)
    ,.stall_fdiv_busy_i(stall_fdiv_busy_i)
    ,.stall_idiv_busy_i(stall_idiv_busy_i)
    ,.stall_barrier_i(stall_barrier_i)
    ,.stall_blocking_load_i(stall_blocking_load_i)
    ,.hit_dram_i(hit_dram)
    ,.hit_group_i(hit_group)
    ,.hit_global_i(hit_global)
    ,.hit_idiv_i(hit_idiv)
    ,.hit_fdiv_i(hit_fdiv)
    ,.exe_bubble_type_o(exe_bubble_type)
    ,.exe_bubble_pc_o(exe_bubble_pc_o)
  );

  assign exe_bubble_type_o = exe_bubble_type;

  bubble_counter_bank #(.cnt_width_p(cnt_width_p)) counters (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.type_i(exe_bubble_type)
    ,.sel_i(cnt_sel_i)
    ,.cnt_o(cnt_o)
  );

endmodule

/* dv/bubble_profiler_tb.sv */
`timescale 1ns/1ps

module bubble_profiler_tb;

  localparam int pc_width_lp = 32;
  localparam int cnt_width_lp = 32;

  logic clk = 1'b0;
  logic reset;
  logic [pc_width_lp-1:0] if_pc, id_pc, exe_pc;
  logic branch_miss, jalr_miss, icache_miss, icache_in_pipe;
  logic stall_all, stall_long_op;
  logic [9:0] stall_lvl; // local_load up to blocking_load.
  rv_isa_pkg::reg_addr_t rs1, rs2, rd;
  logic read_rs1, read_rs2, write_rd, is_float;
  logic sb_set, sb_set_float;
  rv_isa_pkg::reg_addr_t sb_set_id;
  bubble_prof_pkg::long_op_e sb_set_kind;
  logic int_clear, float_clear;
  rv_isa_pkg::reg_addr_t int_clear_id, float_clear_id;
  bubble_prof_pkg::cause_sel_t cnt_sel;
  bubble_prof_pkg::exe_bubble_e bubble_type;
  logic [pc_width_lp-1:0] bubble_pc;
  logic [cnt_width_lp-1:0] cnt;

  // reference state.
  int ref_int_sb [rv_isa_pkg::reg_els_gp];
  int ref_fp_sb [rv_isa_pkg::reg_els_gp];
  logic [cnt_width_lp-1:0] ref_cnt [bubble_prof_pkg::num_causes_gp];
  int ref_id_type, ref_exe_type, next_id_type, next_exe_type;
  logic [pc_width_lp-1:0] ref_id_pc, ref_exe_pc, next_id_pc, next_exe_pc;
  logic [pc_width_lp-1:0] ref_icache_pc = '0;
  string cur_test = "reset_test";

  bubble_profiler_top #(.pc_width_p(pc_width_lp), .cnt_width_p(cnt_width_lp)) dut (
    .clk_i(clk)
    ,.reset_i(reset)
    ,.if_pc_i(if_pc)
    ,.id_pc_i(id_pc)
    ,.exe_pc_i(exe_pc)
    ,.branch_mispredict_i(branch_miss)
    ,.jalr_mispredict_i(jalr_miss)
    ,.icache_miss_i(icache_miss)
    ,.icache_miss_in_pipe_i(icache_in_pipe)
    ,.stall_all_i(stall_all)
    ,.stall_depend_long_op_i(stall_long_op)
    ,.stall_depend_local_load_i(stall_lvl[0])
    ,.stall_depend_imul_i(stall_lvl[1])
    ,.stall_bypass_i(stall_lvl[2])
    ,.stall_fence_i(stall_lvl[3])
    ,.stall_remote_req_i(stall_lvl[4])
    ,.stall_remote_credit_i(stall_lvl[5])
    ,.stall_fdiv_busy_i(stall_lvl[6])
    ,.stall_idiv_busy_i(stall_lvl[7])
    ,.stall_barrier_i(stall_lvl[8])
    ,.stall_blocking_load_i(stall_lvl[9])
    ,.id_rs1_i(rs1)
    ,.id_rs2_i(rs2)
    ,.id_rd_i(rd)
    ,.id_read_rs1_i(read_rs1)
    ,.id_read_rs2_i(read_rs2)
    ,.id_write_rd_i(write_rd)
    ,.id_is_float_i(is_float)
    ,.sb_set_i(sb_set)
    ,.sb_set_float_i(sb_set_float)
    ,.sb_set_id_i(sb_set_id)
    ,.sb_set_kind_i(sb_set_kind)
    ,.int_sb_clear_i(int_clear)
    ,.int_sb_clear_id_i(int_clear_id)
    ,.float_sb_clear_i(float_clear)
    ,.float_sb_clear_id_i(float_clear_id)
    ,.cnt_sel_i(cnt_sel)
    ,.exe_bubble_type_o(bubble_type)
    ,.exe_bubble_pc_o(bubble_pc)
    ,.cnt_o(cnt)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // priority rules
  ////////////////////////////////////////////////////////////////////////////

  // lowest raised plain level wins.
  function automatic int top_level(logic [9:0] lvl);
    int cause;
    cause = 0;
    for (int i = 9; i >= 0; i--) begin
      if (lvl[i]) cause = int'(bubble_prof_pkg::e_exe_depend_local_load) + i;
    end
    return cause;
  endfunction

  function automatic int kind_at(rv_isa_pkg::reg_addr_t r);
    return is_float ? ref_fp_sb[r] : ref_int_sb[r];
  endfunction

  // dram kind maps onto depend_dram, the others follow in order.
  function automatic int stronger_cause(int best, int kind);
    int cause;
    cause = int'(bubble_prof_pkg::e_exe_depend_dram) + kind - 1;
    if (kind == 0 || (best != 0 && best < cause)) return best;
    return cause;
  endfunction

  function automatic int stall_cause();
    int best;
    best = top_level(stall_lvl);
    if (stall_long_op) begin
      if (read_rs1) best = stronger_cause(best, kind_at(rs1));
      if (read_rs2) best = stronger_cause(best, kind_at(rs2));
      if (write_rd) best = stronger_cause(best, kind_at(rd));
    end
    return best;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      ref_id_type = 0;
      ref_id_pc = '0;
      ref_exe_type = 0;
      ref_exe_pc = '0;
      for (int i = 0; i < rv_isa_pkg::reg_els_gp; i++) begin
        ref_int_sb[i] = 0;
        ref_fp_sb[i] = 0;
      end
      for (int i = 0; i < bubble_prof_pkg::num_causes_gp; i++) begin
        ref_cnt[i] = '0;
      end
    end else begin
      if (ref_exe_type != 0 && ref_cnt[ref_exe_type] != '1) begin
        ref_cnt[ref_exe_type] = ref_cnt[ref_exe_type] + cnt_width_lp'(1);
      end
      next_id_type = 0; // id record uses the matching exe codes.
      next_id_pc = '0;
      if (branch_miss || jalr_miss) begin
        next_id_type = branch_miss ? int'(bubble_prof_pkg::e_exe_branch_miss)
                                   : int'(bubble_prof_pkg::e_exe_jalr_miss);
        next_id_pc = exe_pc;
      end else if (icache_in_pipe) begin
        next_id_type = int'(bubble_prof_pkg::e_exe_icache_miss);
        next_id_pc = ref_icache_pc;
      end
      if (branch_miss || jalr_miss) begin
        next_exe_type = next_id_type;
        next_exe_pc = exe_pc;
      end else if (ref_id_type != 0) begin
        next_exe_type = ref_id_type;
        next_exe_pc = ref_id_pc;
      end else begin
        next_exe_type = stall_cause();
        next_exe_pc = (next_exe_type != 0) ? id_pc : '0;
      end
      if (!stall_all) begin
        ref_id_type = next_id_type;
        ref_id_pc = next_id_pc;
        ref_exe_type = next_exe_type;
        ref_exe_pc = next_exe_pc;
      end
      if (icache_miss) ref_icache_pc = if_pc;
      if (sb_set) begin
        if (sb_set_float || sb_set_kind == bubble_prof_pkg::e_long_fdiv) begin
          ref_fp_sb[sb_set_id] = int'(sb_set_kind);
        end else begin
          ref_int_sb[sb_set_id] = int'(sb_set_kind);
        end
      end
      if (int_clear) ref_int_sb[int_clear_id] = 0;
      if (float_clear) ref_fp_sb[float_clear_id] = 0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(string name, int expected, int actual);
    if (expected != actual) begin
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // model and dut compared after every edge.
  always @(negedge clk) begin
    if (!reset) begin
      check($sformatf("%s model type", cur_test), ref_exe_type, int'(bubble_type));
      check($sformatf("%s model pc", cur_test), int'(ref_exe_pc), int'(bubble_pc));
    end
  end

  task automatic step();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic idle_inputs();
    {if_pc, id_pc, exe_pc} = '0;
    {branch_miss, jalr_miss, icache_miss, icache_in_pipe} = '0;
    {stall_all, stall_long_op, stall_lvl} = '0;
    {rs1, rs2, rd, read_rs1, read_rs2, write_rd, is_float} = '0;
    {sb_set, sb_set_float, sb_set_id} = '0;
    sb_set_kind = bubble_prof_pkg::e_long_none;
    {int_clear, int_clear_id, float_clear, float_clear_id} = '0;
    cnt_sel = '0;
  endtask

  task automatic wait_idle(string name);
    int cycles;
    cycles = 0;
    while (bubble_type != bubble_prof_pkg::e_exe_none) begin
      if (cycles == 8) begin
        $display("%s timed out waiting for the bubble type to return to none", name);
        $display(">>> FAIL");
        $fatal(1, "timeout in %s", name);
      end
      step();
      cycles++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_test();
    cur_test = "reset_test";
    check("reset_test type", 0, int'(bubble_type));
    check("reset_test pc", 0, int'(bubble_pc));
    for (int i = 0; i < 32; i++) begin
      cnt_sel = bubble_prof_pkg::cause_sel_t'(i);
      step();
      check("reset_test counter", 0, int'(cnt));
    end
    cnt_sel = '0;
    step();
  endtask

  task automatic miss_test();
    cur_test = "miss_test";
    exe_pc = 32'h0000_1000;
    branch_miss = 1'b1;
    jalr_miss = 1'b1; // branch wins.
    step();
    check("miss_test branch", int'(bubble_prof_pkg::e_exe_branch_miss), int'(bubble_type));
    check("miss_test branch pc", 32'h0000_1000, int'(bubble_pc));
    {branch_miss, jalr_miss} = '0;
    exe_pc = 32'h0000_2000;
    step();
    check("miss_test forward", int'(bubble_prof_pkg::e_exe_branch_miss), int'(bubble_type));
    check("miss_test forward pc", 32'h0000_1000, int'(bubble_pc));
    step();
    check("miss_test idle", 0, int'(bubble_type));
    jalr_miss = 1'b1;
    exe_pc = 32'h0000_3000;
    step();
    jalr_miss = 1'b0;
    check("miss_test jalr", int'(bubble_prof_pkg::e_exe_jalr_miss), int'(bubble_type));
    check("miss_test jalr pc", 32'h0000_3000, int'(bubble_pc));
    wait_idle("miss_test");
    if_pc = 32'h0000_4000;
    icache_miss = 1'b1;
    step();
    icache_miss = 1'b0;
    if_pc = 32'h0000_4004;
    icache_in_pipe = 1'b1;
    step();
    icache_in_pipe = 1'b0;
    step();
    check("miss_test icache", int'(bubble_prof_pkg::e_exe_icache_miss), int'(bubble_type));
    check("miss_test icache pc", 32'h0000_4000, int'(bubble_pc));
    wait_idle("miss_test");
  endtask

  task automatic scoreboard_test();
    cur_test = "scoreboard_test";
    sb_set = 1'b1;
    sb_set_id = 5'd5;
    sb_set_kind = bubble_prof_pkg::e_long_remote_dram;
    step();
    sb_set = 1'b0;
    id_pc = 32'h0000_5000;
    rs1 = 5'd5;
    read_rs1 = 1'b1;
    stall_long_op = 1'b1;
    stall_lvl = 10'b1;
    step();
    check("scoreboard_test dram", int'(bubble_prof_pkg::e_exe_depend_dram), int'(bubble_type));
    check("scoreboard_test dram pc", 32'h0000_5000, int'(bubble_pc));
    {stall_long_op, stall_lvl} = '0;
    int_clear = 1'b1;
    int_clear_id = 5'd5;
    step();
    int_clear = 1'b0;
    stall_long_op = 1'b1;
    stall_lvl = 10'b1;
    step();
    check("scoreboard_test cleared", int'(bubble_prof_pkg::e_exe_depend_local_load),
          int'(bubble_type));
    check("scoreboard_test cleared pc", 32'h0000_5000, int'(bubble_pc));
    // fdiv goes to the float file with no float flag.
    {stall_long_op, stall_lvl, read_rs1} = '0;
    sb_set = 1'b1;
    sb_set_id = 5'd3;
    sb_set_kind = bubble_prof_pkg::e_long_fdiv;
    step();
    sb_set = 1'b0;
    is_float = 1'b1;
    rs2 = 5'd3;
    read_rs2 = 1'b1;
    stall_long_op = 1'b1;
    stall_lvl = 10'b1;
    id_pc = 32'h0000_6000;
    step();
    check("scoreboard_test fdiv", int'(bubble_prof_pkg::e_exe_depend_fdiv), int'(bubble_type));
    check("scoreboard_test fdiv pc", 32'h0000_6000, int'(bubble_pc));
    is_float = 1'b0;
    step();
    check("scoreboard_test int file", int'(bubble_prof_pkg::e_exe_depend_local_load),
          int'(bubble_type));
    idle_inputs();
    float_clear = 1'b1;
    float_clear_id = 5'd3;
    step();
    float_clear = 1'b0;
    wait_idle("scoreboard_test");
  endtask

  task automatic random_stall_test();
    int expected;
    cur_test = "random_stall_test";
    for (int n = 0; n < 200; n++) begin
      stall_lvl = 10'($urandom & $urandom);
      id_pc = $urandom;
      step();
      expected = top_level(stall_lvl);
      check("random_stall_test type", expected, int'(bubble_type));
      check("random_stall_test pc", (expected == 0) ? 0 : int'(id_pc), int'(bubble_pc));
    end
    idle_inputs();
    step();
    wait_idle("random_stall_test");
  endtask

  task automatic freeze_count_test();
    cur_test = "freeze_count_test";
    id_pc = 32'h0000_7000;
    stall_lvl[2] = 1'b1; // bypass.
    step();
    check("freeze_count_test setup", int'(bubble_prof_pkg::e_exe_bypass), int'(bubble_type));
    stall_all = 1'b1;
    for (int n = 0; n < 10; n++) begin
      stall_lvl = 10'($urandom);
      id_pc = $urandom;
      exe_pc = $urandom;
      branch_miss = 1'($urandom);
      step();
      check("freeze_count_test type", int'(bubble_prof_pkg::e_exe_bypass), int'(bubble_type));
      check("freeze_count_test pc", 32'h0000_7000, int'(bubble_pc));
    end
    idle_inputs();
    step();
    wait_idle("freeze_count_test");
    for (int i = 0; i < bubble_prof_pkg::num_causes_gp; i++) begin
      cnt_sel = bubble_prof_pkg::cause_sel_t'(i);
      step();
      check($sformatf("freeze_count_test counter %0d", i), int'(ref_cnt[i]), int'(cnt));
    end
    cnt_sel = '0;
  endtask

  initial begin
    void'($urandom(1));
    reset = 1'b1;
    idle_inputs();
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_test();
    miss_test();
    scoreboard_test();
    random_stall_test();
    freeze_count_test();
    $display(">>> PASS");
    $finish;
  end

endmodule

/* sim.f */
hdl/rv_isa_pkg.sv
hdl/bubble_prof_pkg.sv
hdl/long_op_scoreboard.sv
hdl/bubble_classifier.sv
hdl/bubble_counter_bank.sv
hdl/bubble_profiler_top.sv
dv/bubble_profiler_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bubble profiler testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module bubble_profiler_tb \
  -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_bin > sim.log 2>&1
run_status=$?

if grep -q ">>> FAIL" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status, see sim.log"
  exit 1
fi

echo "simulation passed"
exit 0
